// ==== filelist.f ====
logic/rgmii_pkg.sv
logic/rgmii_ddr_capture.sv
logic/rgmii_rx_decoder.sv
logic/rgmii_inband_status.sv
logic/rgmii_rx_stats.sv
logic/rgmii_rx_bridge.sv
tb/rgmii_rx_bridge_assert.sv
tb/rgmii_rx_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the RGMII receive bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# Assertion failures are counted by the testbench, so the run continues past them
verilator --binary --timing --assert --top-module rgmii_rx_bridge_tb -f filelist.f \
	&& ./obj_dir/Vrgmii_rx_bridge_tb +verilator+error+limit+1000 > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q "Finished with no errors" sim.log 2>/dev/null \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

// ==== tb/rgmii_rx_bridge_tb.sv ====
`timescale 1ns/100ps

module rgmii_rx_bridge_tb import rgmii_pkg::*; ();

	logic        gmii_rxc;
	logic        rst_n;
	logic [3:0]  rgmii_rxd;
	logic        rgmii_rx_ctl;
	gmii_bus_t   gmii_rx_bus;
	logic        link_up;
	lspeed_t     link_speed;
	logic        false_carrier;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	reg_addr_t   wb_adr;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack;

	integer      seed;
	int          err_cnt;
	int          timeout_cnt;
	// Reference counts kept from the stimulus itself
	int          exp_frames;
	int          exp_err_frames;
	int          exp_fc;
	// Link state last announced by the idle symbols
	logic        cur_link;
	lspeed_t     cur_speed;

	rgmii_rx_bridge #(
		.CNT_WIDTH (16)
	) dut_i (
		.gmii_rxc      (gmii_rxc),
		.rst_n         (rst_n),
		.rgmii_rxd     (rgmii_rxd),
		.rgmii_rx_ctl  (rgmii_rx_ctl),
		.gmii_rx_bus   (gmii_rx_bus),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack        (wb_ack)
	);

	initial begin
		gmii_rxc = 1'b0;
		forever #5 gmii_rxc = ~gmii_rxc;
	end

	////////////////////////////////////////////////////////////
	// RGMII pin stimulus

	// Rise half goes out at the falling edge so the rising sample sees it
	// Fall half goes out at the rising edge for the next falling sample
	task automatic send_period(input logic [3:0] rise_nib, input logic rise_ctl,
		input logic [3:0] fall_nib, input logic fall_ctl);
		@(negedge gmii_rxc);
		rgmii_rxd    <= rise_nib;
		rgmii_rx_ctl <= rise_ctl;
		@(posedge gmii_rxc);
		rgmii_rxd    <= fall_nib;
		rgmii_rx_ctl <= fall_ctl;
	endtask

	// Status nibble is duplex, speed, link from bit 3 down
	task automatic send_idle(input logic link, input lspeed_t speed, input int count);
		logic [3:0] nib;
		cur_link  = link;
		cur_speed = speed;
		nib = {1'b1, speed, link};
		for (int i = 0; i < count; i++)
			send_period(nib, 1'b0, nib, 1'b0);
	endtask

	// Random bytes at the current speed, er on the middle byte if asked
	task automatic send_frame(input int len, input logic with_er);
		logic [31:0] rnd;
		logic [7:0]  b;
		logic        er_bit;
		for (int i = 0; i < len; i++) begin
			rnd = $random(seed);
			b = rnd[7:0];
			er_bit = with_er && (i == len / 2);
			// ctl fall half carries en XOR er
			if (cur_speed == link_speed_1000m) begin
				send_period(b[3:0], 1'b1, b[7:4], !er_bit);
			end else begin
				// 10/100 repeats each nibble on both edges, low nibble first
				send_period(b[3:0], 1'b1, b[3:0], !er_bit);
				send_period(b[7:4], 1'b1, b[7:4], 1'b1);
			end
		end
		exp_frames++;
		if (with_er)
			exp_err_frames++;
		// Inter-frame gap
		send_idle(cur_link, cur_speed, 12);
	endtask

	// en low with er high and data 0x0e
	task automatic send_false_carrier();
		send_period(4'he, 1'b0, 4'h0, 1'b1);
		exp_fc++;
		send_idle(cur_link, cur_speed, 6);
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone master

	task automatic wait_for_ack(output logic seen);
		int waited;
		waited = 0;
		seen = 1'b0;
		// Sampled mid-cycle, well clear of the edge that moves ack
		while (!seen && waited < 16) begin
			@(negedge gmii_rxc);
			seen = wb_ack;
			waited++;
		end
		if (!seen) begin
			$display("Wishbone ack did not arrive within 16 cycles at %0t", $time);
			timeout_cnt++;
		end
	endtask

	task automatic wb_transfer(input logic we, input reg_addr_t addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		logic seen;
		@(posedge gmii_rxc);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= addr;
		wb_dat_i <= wdata;
		wait_for_ack(seen);
		rdata = wb_dat_o;
		// Request drops on the edge that closes the ack cycle
		@(posedge gmii_rxc);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic check_reg(input reg_addr_t addr, input logic [31:0] expected);
		logic [31:0] got;
		wb_transfer(1'b0, addr, 32'h0, got);
		if (got !== expected) begin
			$display("Error wb_dat_o %s: expected %h, got %h", addr.name(), expected, got);
			err_cnt++;
		end
	endtask

	task automatic check_status();
		check_reg(reg_status, {29'd0, cur_speed, cur_link});
	endtask

	task automatic check_counters();
		check_reg(reg_frames, exp_frames);
		check_reg(reg_err_frames, exp_err_frames);
		check_reg(reg_false_carrier, exp_fc);
	endtask

	// Any write value clears, so a random one is used
	task automatic write_reg(input reg_addr_t addr);
		logic [31:0] rnd;
		logic [31:0] unused;
		rnd = $random(seed);
		wb_transfer(1'b1, addr, rnd, unused);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 32'h4f28_a80f;
		err_cnt = 0;
		timeout_cnt = 0;
		exp_frames = 0;
		exp_err_frames = 0;
		exp_fc = 0;
		rst_n        <= 1'b0;
		rgmii_rxd    <= 4'h0;
		rgmii_rx_ctl <= 1'b0;
		wb_cyc       <= 1'b0;
		wb_stb       <= 1'b0;
		wb_we        <= 1'b0;
		wb_adr       <= reg_status;
		wb_dat_i     <= 32'h0;
		repeat (8) @(posedge gmii_rxc);
		rst_n <= 1'b1;

		// Gigabit link, whole bytes per period
		send_idle(1'b1, link_speed_1000m, 8);
		check_status();
		send_frame(16, 1'b0);
		send_frame(9, 1'b1);
		send_frame(24, 1'b0);
		check_counters();

		// 100M then 10M, bytes built from nibble pairs
		send_idle(1'b1, link_speed_100m, 8);
		check_status();
		send_frame(12, 1'b0);
		send_frame(10, 1'b1);
		send_idle(1'b1, link_speed_10m, 8);
		check_status();
		send_frame(8, 1'b1);
		send_frame(14, 1'b0);

		send_false_carrier();
		send_false_carrier();
		send_false_carrier();
		check_counters();

		// Counter clears, status ignores writes
		write_reg(reg_frames);
		exp_frames = 0;
		write_reg(reg_err_frames);
		exp_err_frames = 0;
		write_reg(reg_false_carrier);
		exp_fc = 0;
		check_counters();
		write_reg(reg_status);
		check_status();

		// Link drop, then counting again after the clear
		send_idle(1'b0, link_speed_100m, 8);
		check_status();
		send_idle(1'b1, link_speed_1000m, 8);
		send_frame(11, 1'b1);
		send_false_carrier();
		check_counters();

		$display("Closing: %0d read errors, %0d timeouts, %0d assertion failures",
			err_cnt, timeout_cnt, dut_i.assert_i.fail_cnt);
		if (err_cnt == 0 && timeout_cnt == 0 && dut_i.assert_i.fail_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== tb/rgmii_rx_bridge_assert.sv ====
`timescale 1ns/100ps

module rgmii_rx_bridge_assert import rgmii_pkg::*; (
	input logic       gmii_rxc,
	input logic       rst_n,
	input logic [3:0] rgmii_rxd,
	input logic       rgmii_rx_ctl,
	input gmii_bus_t  gmii_rx_bus,
	input logic       link_up,
	input lspeed_t    link_speed,
	input logic       false_carrier,
	input logic       wb_ack
);

	// Count of assertion failures
	int fail_cnt = 0;

	// Pin values at the falling edge as the capture cell sees them
	logic [3:0] fall_nib;
	logic       fall_ctl;
	logic       gig;

	assign gig = (link_speed == link_speed_1000m);

	always_ff @(negedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			fall_nib <= 4'h0;
			fall_ctl <= 1'b0;
		end else begin
			fall_nib <= rgmii_rxd;
			fall_ctl <= rgmii_rx_ctl;
		end
	end

	////////////////////////////////////////////////////////////
	// In-band status against delayed pins

	// Both ctl halves low mark an idle period, rise half three edges back
	status_follows_idle: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		!$past(rgmii_rx_ctl, 3) && !$past(fall_ctl, 2) |=>
			link_up == $past(rgmii_rxd[0], 4) &&
			link_speed == lspeed_t'($past(rgmii_rxd[2:1], 4)))
		else begin
			$error("link state does not follow idle symbol");
			fail_cnt++;
		end

	// Symbol 0x0e with en low and er high
	false_carrier_pulse: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		!$past(rgmii_rx_ctl, 3) && $past(fall_ctl, 2) &&
			{$past(fall_nib, 2), $past(rgmii_rxd, 3)} == 8'h0e |=> false_carrier)
		else begin
			$error("false carrier symbol gave no pulse");
			fail_cnt++;
		end

	false_carrier_single: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		false_carrier |=> !false_carrier)
		else begin
			$error("false_carrier longer than one cycle");
			fail_cnt++;
		end

	////////////////////////////////////////////////////////////
	// Decoder output against delayed pins

	// Rise nibble sampled three edges back and its fall nibble two back
	gig_byte_match: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		gig && $past(rgmii_rx_ctl, 3) |->
			gmii_rx_bus.dvalid && gmii_rx_bus.data == {$past(fall_nib, 2), $past(rgmii_rxd, 3)})
		else begin
			$error("gigabit byte wrong or missing");
			fail_cnt++;
		end

	// Low nibble from the period before the one carrying the high nibble
	mii_byte_match: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		!gig && gmii_rx_bus.dvalid |->
			gmii_rx_bus.data == {$past(fall_nib, 2), $past(rgmii_rxd, 4)})
		else begin
			$error("10/100 byte not built from nibble pair");
			fail_cnt++;
		end

	mii_first_cycle: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		!gig && gmii_rx_bus.en && !$past(gmii_rx_bus.en) |-> !gmii_rx_bus.dvalid)
		else begin
			$error("dvalid high in first cycle of frame");
			fail_cnt++;
		end

	mii_dvalid_gap: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		!gig && gmii_rx_bus.dvalid |=> !gmii_rx_bus.dvalid)
		else begin
			$error("dvalid high two cycles in a row");
			fail_cnt++;
		end

	// Every second cycle of a frame completes a byte
	mii_dvalid_cadence: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		!gig && gmii_rx_bus.en && $past(gmii_rx_bus.en) && !$past(gmii_rx_bus.dvalid) |->
			gmii_rx_bus.dvalid)
		else begin
			$error("dvalid missing on second cycle of a 10/100 byte");
			fail_cnt++;
		end

	// en is the rise ctl half and er needs en with the fall half low
	er_inside_frame: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		gmii_rx_bus.en == $past(rgmii_rx_ctl, 3) &&
		gmii_rx_bus.er == ($past(rgmii_rx_ctl, 3) && !$past(fall_ctl, 2)))
		else begin
			$error("en or er does not match the ctl halves");
			fail_cnt++;
		end

	////////////////////////////////////////////////////////////
	// Wishbone handshake

	ack_one_cycle: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack held for two cycles");
			fail_cnt++;
		end

endmodule

bind rgmii_rx_bridge rgmii_rx_bridge_assert assert_i (
	.gmii_rxc      (gmii_rxc),
	.rst_n         (rst_n),
	.rgmii_rxd     (rgmii_rxd),
	.rgmii_rx_ctl  (rgmii_rx_ctl),
	.gmii_rx_bus   (gmii_rx_bus),
	.link_up       (link_up),
	.link_speed    (link_speed),
	.false_carrier (false_carrier),
	.wb_ack        (wb_ack)
);

// ==== logic/rgmii_rx_bridge.sv ====
`timescale 1ns/100ps

module rgmii_rx_bridge import rgmii_pkg::*; #(
	parameter int CNT_WIDTH = 16
) (
	input  logic        gmii_rxc,
	input  logic        rst_n,
	// RGMII receive pins from the PHY
	input  logic [3:0]  rgmii_rxd,
	input  logic        rgmii_rx_ctl,
	// GMII toward the MAC
	output gmii_bus_t   gmii_rx_bus,
	// In-band link state
	output logic        link_up,
	output lspeed_t     link_speed,
	output logic        false_carrier,
	// Wishbone classic slave
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  reg_addr_t   wb_adr,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack
);

	// Both edges of one period
	ddr_pair_t rx_pair;
	// Idle symbol for the status decoder
	inband_t   inband;

	////////////////////////////////////////////////////////////
	// Datapath: capture, decode, status

	rgmii_ddr_capture capture_i (
		.gmii_rxc     (gmii_rxc),
		.rst_n        (rst_n),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.rx_pair      (rx_pair)
	);

	// Speed loops back from the status block to steer byte assembly
	rgmii_rx_decoder decoder_i (
		.gmii_rxc    (gmii_rxc),
		.rst_n       (rst_n),
		.rx_pair     (rx_pair),
		.link_speed  (link_speed),
		.gmii_rx_bus (gmii_rx_bus),
		.inband      (inband)
	);

	rgmii_inband_status status_i (
		.gmii_rxc      (gmii_rxc),
		.rst_n         (rst_n),
		.inband        (inband),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier)
	);

	////////////////////////////////////////////////////////////
	// Register block

	rgmii_rx_stats #(
		.CNT_WIDTH (CNT_WIDTH)
	) stats_i (
		.gmii_rxc      (gmii_rxc),
		.rst_n         (rst_n),
		.gmii_rx_bus   (gmii_rx_bus),
		.false_carrier (false_carrier),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack        (wb_ack)
	);

endmodule

// ==== logic/rgmii_rx_stats.sv ====
`timescale 1ns/100ps

module rgmii_rx_stats import rgmii_pkg::*; #(
	parameter int CNT_WIDTH = 16
) (
	input  logic        gmii_rxc,
	input  logic        rst_n,
	input  gmii_bus_t   gmii_rx_bus,
	input  logic        false_carrier,
	input  logic        link_up,
	input  lspeed_t     link_speed,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  reg_addr_t   wb_adr,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack
);

	// Counter stops at all ones instead of wrapping
	function automatic logic [CNT_WIDTH-1:0] sat_inc(input logic [CNT_WIDTH-1:0] cnt);
		if (cnt == {CNT_WIDTH{1'b1}})
			return cnt;
		else
			return cnt + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Frame tracking

	logic en_q;
	// Some er seen since the frame began
	logic err_seen;
	// First idle cycle after a frame
	logic frame_end;

	assign frame_end = en_q && !gmii_rx_bus.en;

	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			en_q     <= 1'b0;
			err_seen <= 1'b0;
		end else begin
			en_q <= gmii_rx_bus.en;
			// er is never high outside en, so no overlap with the clear
			if (gmii_rx_bus.er)
				err_seen <= 1'b1;
			else if (frame_end)
				err_seen <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Wishbone request decode

	// The ack cycle itself does not count as a second request
	logic wb_req;
	logic wr_req;

	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	// Write data is ignored and any value clears the counter
	assign wr_req = wb_req && wb_we;

	////////////////////////////////////////////////////////////
	// Counters

	logic [CNT_WIDTH-1:0] frame_cnt;
	logic [CNT_WIDTH-1:0] err_frame_cnt;
	logic [CNT_WIDTH-1:0] fc_cnt;

	// Clear by write wins over a same-cycle event
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt     <= '0;
			err_frame_cnt <= '0;
			fc_cnt        <= '0;
		end else begin
			if (wr_req && (wb_adr == reg_frames))
				frame_cnt <= '0;
			else if (frame_end)
				frame_cnt <= sat_inc(frame_cnt);

			if (wr_req && (wb_adr == reg_err_frames))
				err_frame_cnt <= '0;
			else if (frame_end && err_seen)
				err_frame_cnt <= sat_inc(err_frame_cnt);

			if (wr_req && (wb_adr == reg_false_carrier))
				fc_cnt <= '0;
			else if (false_carrier)
				fc_cnt <= sat_inc(fc_cnt);
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux and ack

	logic [31:0] rd_data;

	always_comb begin
		case (wb_adr)
			reg_status:        rd_data = {29'd0, link_speed, link_up};
			reg_frames:        rd_data = 32'(frame_cnt);
			reg_err_frames:    rd_data = 32'(err_frame_cnt);
			reg_false_carrier: rd_data = 32'(fc_cnt);
			default:           rd_data = 32'd0;
		endcase
	end

	// One-cycle ack with the read data in the same cycle
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			wb_dat_o <= 32'd0;
		end else begin
			wb_ack <= wb_req;
			if (wb_req)
				wb_dat_o <= rd_data;
		end
	end

endmodule

// ==== logic/rgmii_inband_status.sv ====
`timescale 1ns/100ps

module rgmii_inband_status import rgmii_pkg::*; (
	input  logic    gmii_rxc,
	input  logic    rst_n,
	input  inband_t inband,
	output logic    link_up,
	output lspeed_t link_speed,
	output logic    false_carrier
);

	// Normal inter-frame gap, status bits are meaningful
	logic status_sym;
	// Special symbol between frames
	logic special_sym;

	assign status_sym  = inband.valid && !inband.er_int;
	assign special_sym = inband.valid && inband.er_int;

	////////////////////////////////////////////////////////////
	// Link state

	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			link_up    <= 1'b0;
			link_speed <= link_speed_10m;
		end else if (status_sym) begin
			// Bit 0 link, bits 2:1 speed
			link_up    <= inband.data[0];
			link_speed <= lspeed_t'(inband.data[2:1]);
		end
	end

	////////////////////////////////////////////////////////////
	// False carrier detect

	// One cycle per symbol, other special symbols fall through
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n)
			false_carrier <= 1'b0;
		else
			false_carrier <= special_sym && (inband.data == 8'h0e);
	end

endmodule

// ==== logic/rgmii_rx_decoder.sv ====
`timescale 1ns/100ps

module rgmii_rx_decoder import rgmii_pkg::*; (
	input  logic      gmii_rxc,
	input  logic      rst_n,
	input  ddr_pair_t rx_pair,
	input  lspeed_t   link_speed,
	output gmii_bus_t gmii_rx_bus,
	output inband_t   inband
);

	////////////////////////////////////////////////////////////
	// Control decode

	// en travels on the rising half of ctl
	logic en_now;
	// er is sent as en XOR er on the falling half
	logic er_int_now;
	// First period of a frame
	logic frame_start;
	logic en_q;

	assign en_now      = rx_pair.ctl_rise;
	assign er_int_now  = rx_pair.ctl_rise ^ rx_pair.ctl_fall;
	assign frame_start = en_now && !en_q;

	////////////////////////////////////////////////////////////
	// Byte assembly

	// Low nibble of the previous period, for 10/100
	logic [3:0] prev_lo;
	// Whole byte from one period at 1000M
	logic [7:0] byte_gig;
	// Byte built across two periods at 10/100
	logic [7:0] byte_mii;
	// High on the period that completes a 10/100 byte
	logic       nib_toggle;

	assign byte_gig = {rx_pair.rxd_fall, rx_pair.rxd_rise};
	// At 10/100 both halves carry the same nibble, so the fall half works
	assign byte_mii = {rx_pair.rxd_fall, prev_lo};

	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n)
			prev_lo <= 4'h0;
		else
			prev_lo <= rx_pair.rxd_rise;
	end

	// Nibble phase toggle, locked to the start of each frame
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			en_q       <= 1'b0;
			nib_toggle <= 1'b0;
		end else begin
			en_q <= en_now;
			// Second period of the frame completes the first byte
			if (frame_start)
				nib_toggle <= 1'b1;
			else
				nib_toggle <= !nib_toggle;
		end
	end

	////////////////////////////////////////////////////////////
	// GMII output register

	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			gmii_rx_bus <= '0;
		end else begin
			gmii_rx_bus.en <= en_now;
			// er only has meaning inside a frame
			gmii_rx_bus.er <= en_now && er_int_now;
			if (link_speed == link_speed_1000m) begin
				// Full byte every cycle
				gmii_rx_bus.data   <= byte_gig;
				gmii_rx_bus.dvalid <= en_now;
			end else begin
				gmii_rx_bus.data   <= byte_mii;
				// The first period holds only half a byte
				gmii_rx_bus.dvalid <= en_now && nib_toggle && !frame_start;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// In-band symbol output

	// Idle periods carry PHY status in step with the GMII bus
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			inband <= '0;
		end else begin
			inband.valid  <= !en_now;
			inband.er_int <= er_int_now;
			inband.data   <= byte_gig;
		end
	end

endmodule

// ==== logic/rgmii_ddr_capture.sv ====
`timescale 1ns/100ps

module rgmii_ddr_capture import rgmii_pkg::*; (
	input  logic       gmii_rxc,
	input  logic       rst_n,
	input  logic [3:0] rgmii_rxd,
	input  logic       rgmii_rx_ctl,
	output ddr_pair_t  rx_pair
);

	////////////////////////////////////////////////////////////
	// Input DDR cell model

	// Rising edge half
	logic [3:0] rxd_rise_q;
	logic       ctl_rise_q;

	// Falling edge half
	logic [3:0] rxd_fall_q;
	logic       ctl_fall_q;

	// Rising edge sample of data and control
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			rxd_rise_q <= 4'h0;
			ctl_rise_q <= 1'b0;
		end else begin
			rxd_rise_q <= rgmii_rxd;
			ctl_rise_q <= rgmii_rx_ctl;
		end
	end

	// Falling edge sample, half a period after the rising one
	// Only place in the design clocked on the falling edge
	always_ff @(negedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			rxd_fall_q <= 4'h0;
			ctl_fall_q <= 1'b0;
		end else begin
			rxd_fall_q <= rgmii_rxd;
			ctl_fall_q <= rgmii_rx_ctl;
		end
	end

	////////////////////////////////////////////////////////////
	// Realign both halves into the rising edge domain

	// The rise register still holds the previous rising sample here,
	// so it pairs with the falling sample that followed it
	always_ff @(posedge gmii_rxc or negedge rst_n) begin
		if (!rst_n) begin
			rx_pair <= '0;
		end else begin
			rx_pair.rxd_rise <= rxd_rise_q;
			rx_pair.rxd_fall <= rxd_fall_q;
			rx_pair.ctl_rise <= ctl_rise_q;
			rx_pair.ctl_fall <= ctl_fall_q;
		end
	end

endmodule

// ==== logic/rgmii_pkg.sv ====
package rgmii_pkg;

	////////////////////////////////////////////////////////////
	// Link speed encoded as in the in-band status bits 2:1

	typedef enum logic [1:0] {
		link_speed_10m   = 2'b00,
		link_speed_100m  = 2'b01,
		link_speed_1000m = 2'b10
	} lspeed_t;

	////////////////////////////////////////////////////////////
	// GMII receive bus toward the MAC

	typedef struct packed {
		// Frame in progress
		logic       en;
		// Receive error inside a frame
		logic       er;
		// Data byte is complete this cycle
		logic       dvalid;
		logic [7:0] data;
	} gmii_bus_t;

	// One captured RGMII clock period with both edges side by side
	typedef struct packed {
		// Nibble sampled on the rising edge (low nibble at 1000M)
		logic [3:0] rxd_rise;
		// Nibble sampled on the following falling edge
		logic [3:0] rxd_fall;
		logic       ctl_rise;
		logic       ctl_fall;
	} ddr_pair_t;

	// Inter-frame symbol handed to the status decoder
	typedef struct packed {
		// Bus idle this cycle
		logic       valid;
		// XOR of the two ctl halves
		logic       er_int;
		logic [7:0] data;
	} inband_t;

	////////////////////////////////////////////////////////////
	// Wishbone word addresses of the register block

	typedef enum logic [1:0] {
		// Status word holds link_up in bit 0 and speed in bits 2:1
		reg_status        = 2'd0,
		reg_frames        = 2'd1,
		reg_err_frames    = 2'd2,
		reg_false_carrier = 2'd3
	} reg_addr_t;

endpackage
